/* source/rv_pkg.sv */
package rv_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    typedef logic [xlen-1:0]       word_t;
    typedef logic [reg_addr_w-1:0] reg_idx_t;

    localparam word_t reset_pc = '0; // first fetch address

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        op_load   = 7'b0000011,
        op_imm    = 7'b0010011,
        op_store  = 7'b0100011,
        op_reg    = 7'b0110011,
        op_lui    = 7'b0110111,
        op_branch = 7'b1100011,
        op_jal    = 7'b1101111
    } opcode_t;

    // funct3 of register and immediate arithmetic
    typedef enum logic [2:0] {
        fn_add = 3'b000, // add, sub, addi
        fn_sll = 3'b001,
        fn_xor = 3'b100,
        fn_srl = 3'b101,
        fn_or  = 3'b110,
        fn_and = 3'b111
    } alu_fn_t;

    // funct3 of conditional branches
    typedef enum logic [2:0] {
        br_beq = 3'b000,
        br_bne = 3'b001,
        br_blt = 3'b100,
        br_bge = 3'b101
    } branch_fn_t;

    typedef struct packed {
        opcode_t    opcode;
        logic [2:0] funct3;
        logic       sub_sel;   // R-type subtract
        reg_idx_t   rs1;
        reg_idx_t   rs2;
        reg_idx_t   rd;
        word_t      imm;       // already sign extended
        logic       use_imm;
        logic       reg_we;
        logic       mem_read;
        logic       mem_write;
        logic       is_branch;
        logic       is_jal;
        logic       valid;     // low for unsupported encodings
    } decoded_t;

    // memory bus request, held stable while the bus is full
    typedef struct packed {
        logic  valid;
        logic  write;
        word_t addr;
        word_t wdata;
    } bus_req_t;

    typedef enum logic [1:0] {
        seq_fetch,
        seq_execute,
        seq_mem,
        seq_writeback
    } seq_state_t;

    typedef enum logic {
        bus_idle,
        bus_access
    } bus_state_t;

endpackage

/* source/decoder.sv */
`timescale 1ns/10ps

module decoder (
    input  rv_pkg::word_t    instr_i,
    output rv_pkg::decoded_t dec_o
);
    import rv_pkg::*;

    opcode_t    opc;
    logic [2:0] funct3;
    logic       fn_ok;  // funct3 is one of the supported ALU ops
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    word_t      imm_j;
    word_t      imm_u;

    always_comb begin
        opc    = opcode_t'(instr_i[6:0]);
        funct3 = instr_i[14:12];
        fn_ok  = (funct3[2:1] != 2'b01); // slt and sltu left out
        imm_i  = {{20{instr_i[31]}}, instr_i[31:20]};
        imm_s  = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
        imm_b  = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                  instr_i[11:8], 1'b0};
        imm_j  = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                  instr_i[30:21], 1'b0};
        imm_u  = {instr_i[31:12], 12'b0};
    end

    always_comb begin
        dec_o        = '0; // unknown opcode leaves every enable low
        dec_o.opcode = opc;
        dec_o.funct3 = funct3;
        dec_o.rs1    = instr_i[19:15];
        dec_o.rs2    = instr_i[24:20];
        dec_o.rd     = instr_i[11:7];
        case (opc)
            op_reg: begin
                dec_o.sub_sel = instr_i[30] && (funct3 == fn_add);
                dec_o.reg_we  = fn_ok;
                dec_o.valid   = fn_ok;
            end
            op_imm: begin
                dec_o.imm     = imm_i; // shifts only look at imm[4:0]
                dec_o.use_imm = 1'b1;
                dec_o.reg_we  = fn_ok;
                dec_o.valid   = fn_ok;
            end
            op_load: begin
                dec_o.imm      = imm_i;
                dec_o.use_imm  = 1'b1;
                dec_o.mem_read = (funct3 == 3'b010); // lw only
                dec_o.reg_we   = (funct3 == 3'b010);
                dec_o.valid    = (funct3 == 3'b010);
            end
            op_store: begin
                dec_o.imm       = imm_s;
                dec_o.mem_write = (funct3 == 3'b010); // sw only
                dec_o.valid     = (funct3 == 3'b010);
            end
            op_branch: begin
                dec_o.imm       = imm_b;
                dec_o.is_branch = ~funct3[1]; // no unsigned compares
                dec_o.valid     = ~funct3[1];
            end
            op_jal: begin
                dec_o.imm    = imm_j;
                dec_o.is_jal = 1'b1;
                dec_o.reg_we = 1'b1; // link register gets pc+4
                dec_o.valid  = 1'b1;
            end
            op_lui: begin
                dec_o.imm     = imm_u;
                dec_o.use_imm = 1'b1;
                dec_o.reg_we  = 1'b1;
                dec_o.valid   = 1'b1;
            end
            default: dec_o.valid = 1'b0;
        endcase
    end

endmodule

/* source/alu.sv */
`timescale 1ns/10ps

module alu (
    input  rv_pkg::decoded_t dec_i,
    input  rv_pkg::word_t    rs1_val_i,
    input  rv_pkg::word_t    rs2_val_i,
    output rv_pkg::word_t    result_o,
    output rv_pkg::word_t    mem_addr_o,
    output logic             take_branch_o
);
    import rv_pkg::*;

    word_t op_b; // second operand

    always_comb begin
        op_b     = dec_i.use_imm ? dec_i.imm : rs2_val_i;
        result_o = '0;
        if (dec_i.opcode == op_lui) begin
            result_o = dec_i.imm; // upper bits already placed by decoder
        end else begin
            case (alu_fn_t'(dec_i.funct3))
                fn_add: begin
                    if (dec_i.sub_sel) begin
                        result_o = rs1_val_i - op_b;
                    end else begin
                        result_o = rs1_val_i + op_b;
                    end
                end
                fn_sll:  result_o = rs1_val_i << op_b[4:0];
                fn_xor:  result_o = rs1_val_i ^ op_b;
                fn_srl:  result_o = rs1_val_i >> op_b[4:0]; // logical
                fn_or:   result_o = rs1_val_i | op_b;
                fn_and:  result_o = rs1_val_i & op_b;
                default: result_o = '0;
            endcase
        end
    end

    // lw and sw effective address
    assign mem_addr_o = rs1_val_i + dec_i.imm;

    always_comb begin
        take_branch_o = 1'b0;
        if (dec_i.is_branch) begin
            case (branch_fn_t'(dec_i.funct3))
                br_beq:  take_branch_o = (rs1_val_i == rs2_val_i);
                br_bne:  take_branch_o = (rs1_val_i != rs2_val_i);
                br_blt:  take_branch_o = ($signed(rs1_val_i) < $signed(rs2_val_i));
                br_bge:  take_branch_o = ($signed(rs1_val_i) >= $signed(rs2_val_i));
                default: take_branch_o = 1'b0;
            endcase
        end
    end

endmodule

/* source/reg_file.sv */
`timescale 1ns/10ps

module reg_file (
    input  logic             clk,
    input  logic             rst,
    input  rv_pkg::reg_idx_t rs1_i,
    input  rv_pkg::reg_idx_t rs2_i,
    input  logic             we_i,
    input  rv_pkg::reg_idx_t waddr_i,
    input  rv_pkg::word_t    wdata_i,
    output rv_pkg::word_t    rs1_val_o,
    output rv_pkg::word_t    rs2_val_o
);
    import rv_pkg::*;

    word_t regs [32];

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && (waddr_i != '0)) begin // x0 never written
            regs[waddr_i] <= wdata_i;
        end
    end

    // combinational read ports
    assign rs1_val_o = regs[rs1_i];
    assign rs2_val_o = regs[rs2_i];

endmodule

/* source/bus_master.sv */
`timescale 1ns/10ps

module bus_master (
    input  logic             clk,
    input  logic             rst,
    input  logic             start_i,
    input  logic             write_i,
    input  rv_pkg::word_t    addr_i,
    input  rv_pkg::word_t    wdata_i,
    output rv_pkg::bus_req_t bus_req_o,
    input  logic             bus_full_i,
    input  rv_pkg::word_t    rdata_i,
    output logic             done_o,
    output rv_pkg::word_t    rdata_o
);
    import rv_pkg::*;

    bus_state_t state;
    logic       req_write;
    word_t      req_addr;
    word_t      req_wdata;
    logic       accept;    // transfer completes at this edge

    assign accept = (state == bus_access) && !bus_full_i;

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            state  <= bus_idle;
            done_o <= 1'b0;
        end else begin
            done_o <= accept; // one cycle after the completing edge
            case (state)
                bus_idle: begin
                    if (start_i) begin
                        state <= bus_access;
                    end
                end
                bus_access: begin
                    if (!bus_full_i) begin
                        state <= bus_idle;
                    end
                end
                default: state <= bus_idle;
            endcase
        end
    end

    // request fields only change on a new start, so they stay put through stalls
    always_ff @(posedge clk) begin
        if (start_i && (state == bus_idle)) begin
            req_write <= write_i;
            req_addr  <= addr_i;
            req_wdata <= wdata_i;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            rdata_o <= rdata_i; // held until the next completion
        end
    end

    always_comb begin
        bus_req_o.valid = (state == bus_access);
        bus_req_o.write = req_write;
        bus_req_o.addr  = req_addr;
        bus_req_o.wdata = req_wdata;
    end

endmodule

/* source/core_seq.sv */
`timescale 1ns/10ps

module core_seq (
    input  logic             clk,
    input  logic             rst,
    input  rv_pkg::decoded_t dec_i,
    input  rv_pkg::word_t    alu_result_i,
    input  rv_pkg::word_t    mem_addr_i,
    input  logic             take_branch_i,
    input  rv_pkg::word_t    rs2_val_i,
    input  logic             bus_done_i,
    input  rv_pkg::word_t    bus_rdata_i,
    output rv_pkg::word_t    instr_o,
    output rv_pkg::word_t    pc_o,
    output logic             bus_start_o,
    output logic             bus_write_o,
    output rv_pkg::word_t    bus_addr_o,
    output rv_pkg::word_t    bus_wdata_o,
    output logic             rf_we_o,
    output rv_pkg::reg_idx_t rf_waddr_o,
    output rv_pkg::word_t    rf_wdata_o
);
    import rv_pkg::*;

    seq_state_t state;
    word_t      pc_q;
    word_t      ir_q;
    word_t      pc_plus4;
    logic       pending;   // bus transfer started, done not yet seen
    logic       bus_phase; // states that own a bus transfer

    assign pc_plus4  = pc_q + 32'd4;
    assign bus_phase = (state == seq_fetch) || (state == seq_mem);
    assign instr_o   = ir_q;
    assign pc_o      = pc_q;

    always_comb begin
        bus_start_o = bus_phase && !pending; // one pulse per transfer
        bus_write_o = (state == seq_mem) && dec_i.mem_write;
        bus_addr_o  = (state == seq_mem) ? mem_addr_i : pc_q;
        bus_wdata_o = rs2_val_i;
        rf_we_o     = (state == seq_writeback) && dec_i.reg_we;
        rf_waddr_o  = dec_i.rd;
        if (dec_i.mem_read) begin
            rf_wdata_o = bus_rdata_i; // still held from the lw transfer
        end else if (dec_i.is_jal) begin
            rf_wdata_o = pc_plus4;
        end else begin
            rf_wdata_o = alu_result_i;
        end
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            state   <= seq_fetch;
            pc_q    <= reset_pc;
            pending <= 1'b0;
        end else begin
            if (bus_start_o) begin
                pending <= 1'b1;
            end else if (bus_done_i) begin
                pending <= 1'b0;
            end
            case (state)
                seq_fetch: begin
                    if (bus_done_i) begin
                        state <= seq_execute;
                    end
                end
                seq_execute: begin
                    if (dec_i.mem_read || dec_i.mem_write) begin
                        state <= seq_mem;
                    end else begin
                        state <= seq_writeback; // also the no-op path
                    end
                end
                seq_mem: begin
                    if (bus_done_i) begin
                        state <= seq_writeback;
                    end
                end
                seq_writeback: begin
                    state <= seq_fetch;
                    if (take_branch_i || dec_i.is_jal) begin
                        pc_q <= pc_q + dec_i.imm; // relative to this instruction
                    end else begin
                        pc_q <= pc_plus4;
                    end
                end
                default: state <= seq_fetch;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if ((state == seq_fetch) && bus_done_i) begin
            ir_q <= bus_rdata_i;
        end
    end

endmodule

/* source/rv_core.sv */
`timescale 1ns/10ps

module rv_core (
    input  logic             clk,
    input  logic             rst,
    output rv_pkg::bus_req_t bus_req_o,
    input  logic             bus_full_i,
    input  rv_pkg::word_t    rdata_i
);
    import rv_pkg::*;

    decoded_t dec;
    word_t    instr;
    word_t    alu_result;
    word_t    mem_addr;
    logic     take_branch;
    word_t    rs1_val;
    word_t    rs2_val;
    logic     bus_start;
    logic     bus_write;
    word_t    bus_addr;
    word_t    bus_wdata;
    logic     bus_done;
    word_t    bus_rdata;
    logic     rf_we;
    reg_idx_t rf_waddr;
    word_t    rf_wdata;

    core_seq i_seq (
        .clk           (clk),
        .rst           (rst),
        .dec_i         (dec),
        .alu_result_i  (alu_result),
        .mem_addr_i    (mem_addr),
        .take_branch_i (take_branch),
        .rs2_val_i     (rs2_val),
        .bus_done_i    (bus_done),
        .bus_rdata_i   (bus_rdata),
        .instr_o       (instr),
        .pc_o          (),          // pc is only seen through fetch addresses
        .bus_start_o   (bus_start),
        .bus_write_o   (bus_write),
        .bus_addr_o    (bus_addr),
        .bus_wdata_o   (bus_wdata),
        .rf_we_o       (rf_we),
        .rf_waddr_o    (rf_waddr),
        .rf_wdata_o    (rf_wdata)
    );

    decoder i_dec (
        .instr_i (instr),
        .dec_o   (dec)
    );

    alu i_alu (
        .dec_i         (dec),
        .rs1_val_i     (rs1_val),
        .rs2_val_i     (rs2_val),
        .result_o      (alu_result),
        .mem_addr_o    (mem_addr),
        .take_branch_o (take_branch)
    );

    reg_file i_rf (
        .clk       (clk),
        .rst       (rst),
        .rs1_i     (dec.rs1),
        .rs2_i     (dec.rs2),
        .we_i      (rf_we),
        .waddr_i   (rf_waddr),
        .wdata_i   (rf_wdata),
        .rs1_val_o (rs1_val),
        .rs2_val_o (rs2_val)
    );

    bus_master i_bus (
        .clk        (clk),
        .rst        (rst),
        .start_i    (bus_start),
        .write_i    (bus_write),
        .addr_i     (bus_addr),
        .wdata_i    (bus_wdata),
        .bus_req_o  (bus_req_o),
        .bus_full_i (bus_full_i),
        .rdata_i    (rdata_i),
        .done_o     (bus_done),
        .rdata_o    (bus_rdata)
    );

endmodule

/* verif/rv_core_assertions.sv */
`timescale 1ns/10ps

module rv_core_assertions (
    input logic             clk,
    input logic             rst,
    input rv_pkg::bus_req_t bus_req_o,
    input logic             bus_full_i
);

    int fail_count = 0; // failed assertions so far

    no_valid_in_reset: assert property (@(posedge clk) rst |-> !bus_req_o.valid)
        else begin
            $error("bus request valid while reset is active");
            fail_count++;
        end

    // request frozen through a stall
    stable_while_full: assert property (@(posedge clk) disable iff (rst)
        (bus_req_o.valid && bus_full_i) |=> $stable(bus_req_o))
        else begin
            $error("bus request changed while the bus was full");
            fail_count++;
        end

    gap_after_transfer: assert property (@(posedge clk) disable iff (rst)
        (bus_req_o.valid && !bus_full_i) |=> !bus_req_o.valid)
        else begin
            $error("valid stayed high after a completed transfer");
            fail_count++;
        end

endmodule

bind rv_core rv_core_assertions i_assert (
    .clk        (clk),
    .rst        (rst),
    .bus_req_o  (bus_req_o),
    .bus_full_i (bus_full_i)
);

/* verif/rv_core_tb.sv */
`timescale 1ns/10ps

module rv_core_tb;
    import rv_pkg::*;

    logic     clk;
    logic     rst;
    bus_req_t bus_req;
    logic     bus_full;
    word_t    rdata;

    word_t mem [1024];  // word array indexed by addr/4
    word_t prog [$];
    word_t exp_addr [$];
    word_t exp_data [$];
    string test_name = "none";
    logic  stall_on = 1'b0;
    logic  first_seen;
    int    store_idx = 0;
    int    errors = 0;
    int    checks = 0;
    int    cycle_count = 0;
    int    cycle_limit = 1000;

    rv_core i_dut (
        .clk        (clk),
        .rst        (rst),
        .bus_req_o  (bus_req),
        .bus_full_i (bus_full),
        .rdata_i    (rdata)
    );

    always #5 clk = ~clk;

    assign rdata = mem[bus_req.addr[11:2]]; // read data in the completing cycle

    function automatic word_t r_type(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                     logic [2:0] f3, logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'h33};
    endfunction

    function automatic word_t i_type(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                     logic [4:0] rd, logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic word_t addi(logic [4:0] rd, logic [4:0] rs1, logic [11:0] imm);
        return i_type(imm, rs1, 3'd0, rd, 7'h13);
    endfunction

    function automatic word_t s_type(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'd2, imm[4:0], 7'h23}; // sw
    endfunction

    function automatic word_t b_type(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                     logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
    endfunction

    function automatic word_t j_type(logic [20:0] imm, logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
    endfunction

    function automatic word_t u_type(logic [19:0] upper, logic [4:0] rd);
        return {upper, rd, 7'h37}; // lui
    endfunction

    // instruction level model that fills the expected store list
    function automatic void run_reference();
        word_t regs [32];
        word_t rmem [1024];
        word_t pc;
        word_t ins;
        word_t a;
        word_t b;
        word_t res;
        word_t addr;
        word_t next_pc;
        word_t imm_i;
        word_t imm_s;
        word_t imm_b;
        word_t imm_j;
        logic  wr;
        logic  taken;
        int    i;
        exp_addr.delete();
        exp_data.delete();
        for (i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        for (i = 0; i < 1024; i++) begin
            rmem[i] = (i < prog.size()) ? prog[i] : '0;
        end
        pc = reset_pc;
        repeat (4000) begin
            ins     = rmem[pc[11:2]];
            a       = regs[ins[19:15]];
            b       = regs[ins[24:20]];
            imm_i   = {{20{ins[31]}}, ins[31:20]};
            imm_s   = {{20{ins[31]}}, ins[31:25], ins[11:7]};
            imm_b   = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
            imm_j   = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
            res     = '0;
            wr      = 1'b0;
            taken   = 1'b0;
            next_pc = pc + 4;
            case (ins[6:0])
                7'h13, 7'h33: begin
                    if (ins[6:0] == 7'h13) begin
                        b = imm_i;
                    end
                    wr = (ins[14:13] != 2'b01); // slt and sltu are not in the subset
                    case (ins[14:12])
                        3'd0:    res = (ins[5] && ins[30]) ? a - b : a + b;
                        3'd1:    res = a << b[4:0];
                        3'd4:    res = a ^ b;
                        3'd5:    res = a >> b[4:0];
                        3'd6:    res = a | b;
                        3'd7:    res = a & b;
                        default: res = '0;
                    endcase
                end
                7'h03: begin
                    addr = a + imm_i;
                    res  = rmem[addr[11:2]];
                    wr   = 1'b1;
                end
                7'h23: begin
                    addr = a + imm_s;
                    exp_addr.push_back(addr);
                    exp_data.push_back(b);
                    rmem[addr[11:2]] = b;
                end
                7'h63: begin
                    case (ins[14:12])
                        3'd0:    taken = (a == b);
                        3'd1:    taken = (a != b);
                        3'd4:    taken = ($signed(a) < $signed(b));
                        3'd5:    taken = ($signed(a) >= $signed(b));
                        default: taken = 1'b0;
                    endcase
                    if (taken) begin
                        next_pc = pc + imm_b;
                    end
                end
                7'h6f: begin
                    res     = pc + 4;
                    wr      = 1'b1;
                    next_pc = pc + imm_j;
                end
                7'h37: begin
                    res = {ins[31:12], 12'b0};
                    wr  = 1'b1;
                end
                default: wr = 1'b0; // unknown opcode just moves on
            endcase
            if (wr && (ins[11:7] != 5'd0)) begin
                regs[ins[11:7]] = res;
            end
            if (next_pc == pc) begin
                return; // jal to itself ends the program
            end
            pc = next_pc;
        end
    endfunction

    task automatic check_value(input string what, input word_t expected, input word_t actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("FAILED %s %s: expected %h, actual %h", test_name, what, expected, actual);
        end
    endtask

    task automatic build_arith();
        int r;
        prog.delete();
        prog.push_back(addi(10, 0, 1024)); // store base
        prog.push_back(u_type(20'h12345, 1));
        prog.push_back(addi(1, 1, 12'h678));
        prog.push_back(addi(2, 0, -5));
        prog.push_back(addi(12, 0, 35)); // only the low 5 bits shift
        prog.push_back(r_type(7'h00, 2, 1, 3'd0, 3));
        prog.push_back(r_type(7'h20, 1, 2, 3'd0, 4)); // sub
        prog.push_back(r_type(7'h00, 2, 1, 3'd4, 5));
        prog.push_back(r_type(7'h00, 2, 1, 3'd6, 6));
        prog.push_back(r_type(7'h00, 2, 1, 3'd7, 7));
        prog.push_back(r_type(7'h00, 12, 1, 3'd1, 8));
        prog.push_back(r_type(7'h00, 12, 2, 3'd5, 9));
        prog.push_back(i_type(7, 2, 3'd1, 11, 7'h13)); // slli
        prog.push_back(i_type(3, 2, 3'd5, 13, 7'h13)); // srli
        prog.push_back(i_type(-1, 1, 3'd4, 14, 7'h13));
        prog.push_back(i_type(-256, 1, 3'd6, 15, 7'h13));
        prog.push_back(i_type(12'h7f0, 2, 3'd7, 16, 7'h13));
        for (r = 1; r <= 16; r++) begin
            prog.push_back(s_type(4 * r, r, 10));
        end
        prog.push_back(j_type(0, 0));
    endtask

    task automatic build_load();
        prog.delete();
        prog.push_back(addi(10, 0, 1024));
        prog.push_back(addi(1, 0, -300));
        prog.push_back(s_type(0, 1, 10));
        prog.push_back(i_type(0, 10, 3'd2, 2, 7'h03)); // lw x2
        prog.push_back(addi(3, 0, 77));
        prog.push_back(r_type(7'h00, 3, 2, 3'd0, 4));
        prog.push_back(s_type(4, 4, 10));
        prog.push_back(i_type(4, 10, 3'd2, 5, 7'h03));
        prog.push_back(s_type(8, 5, 10));
        prog.push_back(j_type(0, 0));
    endtask

    task automatic build_control();
        prog.delete();
        prog.push_back(addi(10, 0, 1024));
        prog.push_back(addi(1, 0, -3));
        prog.push_back(addi(2, 0, 5));
        prog.push_back(addi(3, 0, 1));
        prog.push_back(b_type(8, 2, 1, 3'd4)); // blt taken
        prog.push_back(addi(3, 0, 99));
        prog.push_back(b_type(8, 2, 1, 3'd5)); // bge not taken
        prog.push_back(addi(3, 3, 16));
        prog.push_back(b_type(8, 1, 1, 3'd0)); // beq taken
        prog.push_back(addi(3, 0, 77));
        prog.push_back(b_type(8, 1, 1, 3'd1)); // bne not taken
        prog.push_back(s_type(0, 3, 10));
        prog.push_back(b_type(8, 1, 2, 3'd5)); // bge taken
        prog.push_back(addi(3, 0, 55));
        prog.push_back(b_type(8, 2, 1, 3'd0)); // beq not taken
        prog.push_back(b_type(8, 2, 1, 3'd1)); // bne taken
        prog.push_back(addi(3, 0, 66));
        prog.push_back(b_type(8, 1, 2, 3'd4)); // blt not taken
        prog.push_back(s_type(4, 3, 10));
        prog.push_back(addi(6, 0, 3)); // loop count
        prog.push_back(addi(7, 7, 5));
        prog.push_back(addi(6, 6, -1));
        prog.push_back(b_type(-8, 0, 6, 3'd1)); // backward bne
        prog.push_back(s_type(8, 7, 10));
        prog.push_back(j_type(8, 5)); // link lands in x5
        prog.push_back(addi(3, 0, 11));
        prog.push_back(s_type(12, 5, 10));
        prog.push_back(s_type(16, 3, 10));
        prog.push_back(j_type(0, 0));
    endtask

    task automatic build_x0();
        prog.delete();
        prog.push_back(addi(10, 0, 1024));
        prog.push_back(addi(0, 0, 123));
        prog.push_back(s_type(0, 0, 10));
        prog.push_back(addi(1, 0, 42));
        prog.push_back(i_type(5, 0, 3'd0, 1, 7'h0b)); // custom opcode
        prog.push_back(i_type(7, 1, 3'd0, 1, 7'h17)); // auipc not supported
        prog.push_back(s_type(4, 1, 10));
        prog.push_back(r_type(7'h00, 1, 0, 3'd0, 2));
        prog.push_back(s_type(8, 2, 10));
        prog.push_back(j_type(0, 0));
    endtask

    task automatic run_test(input string name, input logic stall);
        int i;
        test_name = name;
        run_reference();
        @(posedge clk);
        rst <= 1'b1;
        repeat (3) @(posedge clk);
        for (i = 0; i < 1024; i++) begin
            mem[i] <= (i < prog.size()) ? prog[i] : '0;
        end
        stall_on    <= stall;
        store_idx   = 0;
        first_seen  = 1'b0;
        cycle_count = 0;
        cycle_limit = prog.size() * 20 * 4 + 50; // 4x headroom for stalls
        rst <= 1'b0;
        wait (store_idx == exp_addr.size());
        repeat (40) @(posedge clk); // catch stray stores
    endtask

    task finish_run();
        errors = errors + i_dut.i_assert.fail_count;
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    endtask

    // bus monitor and store compare
    always @(posedge clk) begin
        if (!rst && bus_req.valid && !bus_full) begin
            if (!first_seen) begin
                check_value("first transfer write", '0, bus_req.write);
                check_value("first transfer addr", reset_pc, bus_req.addr);
                first_seen = 1'b1;
            end
            if (bus_req.write) begin
                mem[bus_req.addr[11:2]] <= bus_req.wdata;
                if (store_idx < exp_addr.size()) begin
                    check_value("store addr", exp_addr[store_idx], bus_req.addr);
                    check_value("store data", exp_data[store_idx], bus_req.wdata);
                end else begin
                    errors++;
                    $display("unexpected store in test %s to address %h", test_name,
                             bus_req.addr);
                end
                store_idx++;
            end
        end
    end

    always @(posedge clk) begin
        if (!rst) begin
            cycle_count++;
            if (cycle_count > cycle_limit) begin
                errors++;
                $display("test %s timed out after %0d cycles", test_name, cycle_limit);
                finish_run();
            end
        end
    end

    // random back-pressure of about 30% when enabled
    initial begin
        bus_full = 1'b0;
        void'($urandom(32'hc574_55c6));
        forever begin
            @(posedge clk);
            bus_full <= stall_on && (($urandom % 100) < 30);
        end
    end

    initial begin
        clk = 1'b0;
        rst = 1'b0; // first reset pulse starts on a clock edge
        build_arith();
        run_test("arith", 1'b0);
        build_load();
        run_test("load", 1'b0);
        build_control();
        run_test("control", 1'b0);
        build_x0();
        run_test("x0_nop", 1'b0);
        build_arith();
        run_test("arith_stall", 1'b1);
        build_load();
        run_test("load_stall", 1'b1);
        build_control();
        run_test("control_stall", 1'b1);
        finish_run();
    end

endmodule

/* verilog.f */
source/rv_pkg.sv
source/decoder.sv
source/alu.sv
source/reg_file.sv
source/bus_master.sv
source/core_seq.sv
source/rv_core.sv
verif/rv_core_assertions.sv
verif/rv_core_tb.sv

/* Bender.yml */
package:
  name: rv_core

sources:
  - source/rv_pkg.sv
  - source/decoder.sv
  - source/alu.sv
  - source/reg_file.sv
  - source/bus_master.sv
  - source/core_seq.sv
  - source/rv_core.sv
  - target: simulation
    files:
      - verif/rv_core_assertions.sv
      - verif/rv_core_tb.sv
